/* files.f */
hw/cache_pkg.sv
hw/cache_meta.sv
hw/cache_ctrl.sv
hw/cache_dpath.sv
hw/blocking_cache.sv
test/tb_clock_gen.sv
test/cache_assertions.sv
test/tb_cache.sv

/* Makefile */
# Verilator build and run for the blocking cache

VERILATOR ?= verilator
TOP       ?= tb_cache
RTL_TOP   ?= blocking_cache
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= ** PASS **
VFLAGS    ?= --timing --assert --timescale 1ns/100ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* test/tb_cache.sv */
//------------------------------
// Cache testbench
// Random traffic against a reference model and a memory model
//------------------------------
`timescale 1ns/100ps

module tb_cache;
  import cache_pkg::*;

  localparam int num_txn    = 400;
  localparam int wait_limit = 200;        // Cycles allowed per wait

  logic        clk;
  logic        reset;
  cache_req_t  proc_req;
  logic        proc_req_val;
  logic        proc_req_rdy;
  cache_resp_t proc_resp;
  logic        proc_resp_val;
  logic        proc_resp_rdy;
  mem_req_t    mem_req;
  logic        mem_req_val;
  logic        mem_req_rdy;
  mem_resp_t   mem_resp;
  logic        mem_resp_val;
  logic        mem_resp_rdy;

  int   seed = 32'hd08c1f23;
  int   mem_seed = 32'hd08c1f23;          // Random stream of the memory model
  int   errors;
  int   checks;
  int   hit_count;
  int   evict_count;
  logic timed_out;

  // Reference model
  word_t ref_mem [addr_t];                // Latest word per word address
  tag_t  m_tag   [num_sets][num_ways];
  logic  m_valid [num_sets][num_ways];
  logic  m_dirty [num_sets][num_ways];
  logic  m_lru   [num_sets];              // Next victim per set

  // Memory model
  line_t    mem_lines [addr_t];           // Keyed by line address
  mem_req_t mem_log [$];                  // Requests seen in this transaction
  tag_t     tag_pool [3];

  tb_clock_gen u_clock (.clk(clk), .reset(reset));

  blocking_cache UUT (
    .clk           (clk),
    .reset         (reset),
    .proc_req      (proc_req),
    .proc_req_val  (proc_req_val),
    .proc_req_rdy  (proc_req_rdy),
    .proc_resp     (proc_resp),
    .proc_resp_val (proc_resp_val),
    .proc_resp_rdy (proc_resp_rdy),
    .mem_req       (mem_req),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_resp      (mem_resp),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy)
  );

  bind blocking_cache cache_assertions u_assertions (
    .clk           (clk),
    .reset         (reset),
    .proc_req_rdy  (proc_req_rdy),
    .proc_resp     (proc_resp),
    .proc_resp_val (proc_resp_val),
    .proc_resp_rdy (proc_resp_rdy),
    .mem_req       (mem_req),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_resp_rdy  (mem_resp_rdy)
  );

  //------------------------------
  // Helpers
  //------------------------------
  // Initial memory word hashed from the full address
  function automatic word_t init_word(addr_t a);
    return ((a ^ 32'h3c6ef372) * 32'h9e3779b1) + {a[15:0], a[31:16]};
  endfunction

  function automatic word_t ref_word(addr_t a);
    if (ref_mem.exists(a)) return ref_mem[a];
    return init_word(a);
  endfunction

  function automatic line_t ref_line(addr_t la);
    line_t l;
    for (int w = 0; w < words_per_line; w++) l[w*32 +: 32] = ref_word(la + w*4);
    return l;
  endfunction

  function automatic line_t mem_read_line(addr_t la);
    line_t l;
    if (mem_lines.exists(la)) return mem_lines[la];
    for (int w = 0; w < words_per_line; w++) l[w*32 +: 32] = init_word(la + w*4);
    return l;
  endfunction

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("timeout at %0t ns: %s", $time, what);
    errors++;
    timed_out = 1'b1;
  endtask

  //------------------------------
  // Processor side
  //------------------------------
  // Entered and left just after a rising edge
  task automatic send_req(input cache_req_t req);
    int   n;
    logic done;
    n = 0;
    done = 1'b0;
    proc_req     = req;
    proc_req_val = 1'b1;
    while (!done && n < wait_limit) begin
      @(negedge clk);
      done = proc_req_rdy;                // Transfer on the next edge
      @(posedge clk);
      #1;
      n++;
    end
    proc_req_val  = 1'b0;
    proc_req.data = $random(seed);        // Cache must keep its own copy
    if (!done) note_timeout("request never accepted by the cache");
  endtask

  // lat is the cycle of the first valid response, with the request transfer in cycle 0
  task automatic wait_resp(output cache_resp_t resp, output int lat);
    int   n;
    logic done;
    n = 0;
    done = 1'b0;
    lat = 0;
    resp = '0;
    while (!done && n < wait_limit) begin
      proc_resp_rdy = ($random(seed) & 3) != 0;   // Random back-pressure
      @(negedge clk);
      if (proc_resp_val && lat == 0) lat = n + 1;
      if (proc_resp_val && proc_resp_rdy) begin
        done = 1'b1;
        resp = proc_resp;
      end
      @(posedge clk);
      #1;
      n++;
    end
    proc_resp_rdy = 1'b0;
    if (!done) note_timeout("no response from the cache");
  endtask

  // One transaction predicted by the model before it is sent
  task automatic run_txn(input req_type_e rt, input addr_t addr, input word_t data);
    index_t      idx;
    tag_t        tag;
    logic        exp_hit;
    logic        evict;
    way_t        w;
    addr_t       evict_addr;
    line_t       evict_line;
    word_t       exp_data;
    cache_req_t  req;
    cache_resp_t resp;
    int          lat;
    int          n_exp;
    int          k;
    idx = addr[offset_bits +: index_bits];
    tag = addr[31 -: tag_bits];
    exp_hit = 1'b0;
    w = m_lru[idx];
    for (int i = 0; i < num_ways; i++) begin
      if (m_valid[idx][i] && m_tag[idx][i] == tag) begin
        exp_hit = 1'b1;
        w = way_t'(i);
      end
    end
    evict      = !exp_hit && m_valid[idx][w] && m_dirty[idx][w];
    evict_addr = {m_tag[idx][w], idx, 4'b0000};
    evict_line = ref_line(evict_addr);   // Latest data of the victim line
    if (!exp_hit) begin
      m_valid[idx][w] = 1'b1;
      m_tag[idx][w]   = tag;
      m_dirty[idx][w] = 1'b0;
    end
    if (rt == req_write) begin
      ref_mem[{addr[31:2], 2'b00}] = data;
      m_dirty[idx][w] = 1'b1;
      exp_data = '0;
    end else begin
      exp_data = ref_word({addr[31:2], 2'b00});
    end
    m_lru[idx] = ~w;
    hit_count   += exp_hit ? 1 : 0;
    evict_count += evict ? 1 : 0;

    mem_log.delete();
    req.req_type = rt;
    req.addr     = addr;
    req.data     = data;
    send_req(req);
    if (timed_out) return;
    wait_resp(resp, lat);
    if (timed_out) return;

    check_val("proc_resp.req_type", 128'(resp.req_type), 128'(rt));
    check_val("proc_resp.hit", 128'(resp.hit), 128'(exp_hit));
    check_val("proc_resp.data", 128'(resp.data), 128'(exp_data));
    if (exp_hit) check_val("hit latency", 128'(lat), 128'(3));

    // Write-back goes out before the refill read
    n_exp = exp_hit ? 0 : (evict ? 2 : 1);
    check_val("mem_req count", 128'(mem_log.size()), 128'(n_exp));
    if (mem_log.size() == n_exp && n_exp > 0) begin
      k = 0;
      if (evict) begin
        check_val("mem_req.req_type", 128'(mem_log[0].req_type), 128'(req_write));
        check_val("mem_req.addr", 128'(mem_log[0].addr), 128'(evict_addr));
        check_val("mem_req.data", mem_log[0].data, evict_line);
        k = 1;
      end
      check_val("mem_req.req_type", 128'(mem_log[k].req_type), 128'(req_read));
      check_val("mem_req.addr", 128'(mem_log[k].addr), 128'({addr[31:4], 4'b0000}));
    end
  endtask

  //------------------------------
  // Memory side
  //------------------------------
  task automatic serve_mem(input mem_req_t req);
    line_t line;
    int    delay;
    int    n;
    logic  done;
    mem_log.push_back(req);
    @(posedge clk);                        // Transfer edge
    #1;
    mem_req_rdy = 1'b0;
    if (req.req_type == req_write) begin
      mem_lines[req.addr] = req.data;
      line = '0;
    end else begin
      line = mem_read_line(req.addr);
    end
    delay = $random(mem_seed) & 3;         // 0 to 3 cycles of latency
    for (n = 0; n < delay; n++) begin
      @(posedge clk);
      #1;
    end
    mem_resp.req_type = req.req_type;
    mem_resp.data     = line;
    mem_resp_val      = 1'b1;
    n = 0;
    done = 1'b0;
    while (!done && n < wait_limit) begin
      @(negedge clk);
      done = mem_resp_rdy;
      @(posedge clk);
      #1;
      n++;
    end
    mem_resp_val = 1'b0;
    mem_resp     = '0;                     // Refill must come from the register
    if (!done) note_timeout("memory response never accepted");
  endtask

  initial begin : memory_model
    mem_req_rdy  = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp     = '0;
    forever begin
      @(posedge clk);
      #1;
      mem_req_rdy = !reset && (($random(mem_seed) & 3) != 0);
      @(negedge clk);
      if (mem_req_val && mem_req_rdy) serve_mem(mem_req);
    end
  end

  //------------------------------
  // Main sequence
  //------------------------------
  initial begin : main
    int        n;
    int        k;
    int        mark;
    logic      done;
    addr_t     a;
    req_type_e rt;
    proc_req      = '0;
    proc_req_val  = 1'b0;
    proc_resp_rdy = 1'b0;
    errors = 0;
    checks = 0;
    hit_count = 0;
    evict_count = 0;
    timed_out = 1'b0;
    tag_pool[0] = 25'h00_00a5;   // Three tags compete for the two ways of each set
    tag_pool[1] = 25'h1b_3c01;
    tag_pool[2] = 25'h07_f00e;
    for (int s = 0; s < num_sets; s++) begin
      m_lru[s] = 1'b0;
      for (int w = 0; w < num_ways; w++) begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_tag[s][w]   = '0;
      end
    end

    // Test 1 checks the outputs right after reset
    mark = errors;
    n = 0;
    done = 1'b0;
    while (!done && n < wait_limit) begin
      @(negedge clk);
      done = !reset;
      n++;
    end
    if (!done) note_timeout("reset never released");
    check_val("proc_req_rdy", 128'(proc_req_rdy), 128'(1'b1));
    check_val("proc_resp_val", 128'(proc_resp_val), 128'(1'b0));
    check_val("mem_req_val", 128'(mem_req_val), 128'(1'b0));
    check_val("mem_resp_rdy", 128'(mem_resp_rdy), 128'(1'b0));
    @(posedge clk);
    #1;
    $display("test 1 reset state: %0d errors", errors - mark);

    // Test 2 runs random reads and writes over the tag pool
    mark = errors;
    for (n = 0; n < num_txn && !timed_out; n++) begin
      k  = $unsigned($random(seed)) % 3;
      a  = {tag_pool[k], index_t'($random(seed)), word_sel_t'($random(seed)), 2'b00};
      rt = ($random(seed) & 1) ? req_write : req_read;
      run_txn(rt, a, $random(seed));
    end
    $display("test 2 random traffic: %0d transactions, %0d hits, %0d dirty evictions, %0d errors",
             n, hit_count, evict_count, errors - mark);

    // Test 3 reads back every word of the pool
    mark = errors;
    for (int t = 0; t < 3; t++) begin
      for (int s = 0; s < num_sets; s++) begin
        for (int w = 0; w < words_per_line; w++) begin
          if (!timed_out) begin
            run_txn(req_read, {tag_pool[t], index_t'(s), word_sel_t'(w), 2'b00}, '0);
          end
        end
      end
    end
    $display("test 3 final sweep: %0d errors", errors - mark);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* test/cache_assertions.sv */
//------------------------------
// Cache handshake assertions
// Reset state, stable senders and a single transaction in flight
//------------------------------
`timescale 1ns/100ps

module cache_assertions (
  input logic                   clk,
  input logic                   reset,
  input logic                   proc_req_rdy,
  input cache_pkg::cache_resp_t proc_resp,
  input logic                   proc_resp_val,
  input logic                   proc_resp_rdy,
  input cache_pkg::mem_req_t    mem_req,
  input logic                   mem_req_val,
  input logic                   mem_req_rdy,
  input logic                   mem_resp_rdy
);
  import cache_pkg::*;

  // Idle outputs on the cycle after reset
  reset_idle: assert property (@(posedge clk)
    reset |=> (proc_req_rdy && !proc_resp_val && !mem_req_val && !mem_resp_rdy))
    else $error("cache outputs not idle after reset");

  // Response held until taken
  resp_stable: assert property (@(posedge clk) disable iff (reset)
    (proc_resp_val && !proc_resp_rdy) |=> (proc_resp_val && $stable(proc_resp)))
    else $error("processor response dropped or changed while stalled");

  // Memory request held until taken
  mem_req_stable: assert property (@(posedge clk) disable iff (reset)
    (mem_req_val && !mem_req_rdy) |=> (mem_req_val && $stable(mem_req)))
    else $error("memory request dropped or changed while stalled");

  // New request only when nothing else is pending
  one_in_flight: assert property (@(posedge clk) disable iff (reset)
    proc_req_rdy |-> (!proc_resp_val && !mem_req_val && !mem_resp_rdy))
    else $error("request accepted while a transaction is open");

endmodule

/* test/tb_clock_gen.sv */
//------------------------------
// Testbench clock and reset
// 4 ns clock, reset held for 8 cycles
//------------------------------
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  // Synchronous reset, released just after an edge
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

/* hw/blocking_cache.sv */
//------------------------------
// Blocking cache top
// Two-way write-back cache between processor and memory streams
//------------------------------
`timescale 1ns/100ps

module blocking_cache (
  input  logic                   clk,
  input  logic                   reset,
  // Processor request
  input  cache_pkg::cache_req_t  proc_req,
  input  logic                   proc_req_val,
  output logic                   proc_req_rdy,
  // Processor response
  output cache_pkg::cache_resp_t proc_resp,
  output logic                   proc_resp_val,
  input  logic                   proc_resp_rdy,
  // Memory request
  output cache_pkg::mem_req_t    mem_req,
  output logic                   mem_req_val,
  input  logic                   mem_req_rdy,
  // Memory response
  input  cache_pkg::mem_resp_t   mem_resp,
  input  logic                   mem_resp_val,
  output logic                   mem_resp_rdy
);
  import cache_pkg::*;

  ctrl_sig_t  ctrl;
  index_t     index;
  logic [1:0] match;
  req_type_e  req_type;
  logic       hit;
  way_t       way;
  logic       victim_dirty;
  logic       set_valid;
  logic       set_dirty;
  logic       clear_dirty;
  logic       lru_update;

  // FSM
  cache_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .proc_req_val  (proc_req_val),
    .proc_req_rdy  (proc_req_rdy),
    .proc_resp_val (proc_resp_val),
    .proc_resp_rdy (proc_resp_rdy),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy),
    .req_type      (req_type),
    .hit           (hit),
    .victim_dirty  (victim_dirty),
    .ctrl          (ctrl),
    .set_valid     (set_valid),
    .set_dirty     (set_dirty),
    .clear_dirty   (clear_dirty),
    .lru_update    (lru_update)
  );

  // Valid, dirty and LRU state
  cache_meta u_meta (
    .clk          (clk),
    .reset        (reset),
    .index        (index),
    .match        (match),
    .set_valid    (set_valid),
    .set_dirty    (set_dirty),
    .clear_dirty  (clear_dirty),
    .lru_update   (lru_update),
    .hit          (hit),
    .way          (way),
    .victim_dirty (victim_dirty)
  );

  // Arrays and message registers
  cache_dpath u_dpath (
    .clk       (clk),
    .proc_req  (proc_req),
    .proc_resp (proc_resp),
    .mem_req   (mem_req),
    .mem_resp  (mem_resp),
    .ctrl      (ctrl),
    .way       (way),
    .index     (index),
    .match     (match),
    .req_type  (req_type)
  );

endmodule

/* hw/cache_dpath.sv */
//------------------------------
// Cache datapath
// Request register, tag and data arrays, memory message assembly
//------------------------------
`timescale 1ns/100ps

module cache_dpath (
  input  logic                   clk,
  input  cache_pkg::cache_req_t  proc_req,
  output cache_pkg::cache_resp_t proc_resp,
  output cache_pkg::mem_req_t    mem_req,
  input  cache_pkg::mem_resp_t   mem_resp,
  input  cache_pkg::ctrl_sig_t   ctrl,
  input  cache_pkg::way_t        way,
  output cache_pkg::index_t      index,
  output logic [1:0]             match,
  output cache_pkg::req_type_e   req_type
);
  import cache_pkg::*;

  // Registers, no reset (payload only)
  cache_req_t req_q;
  word_t      read_word_q;
  addr_t      evict_addr_q;
  line_t      mem_line_q;       // Refill line from memory

  // Arrays, guarded by the valid bits in cache_meta
  tag_t  tag_array  [num_ways][num_sets];
  line_t data_array [num_ways][num_sets];

  tag_t      req_tag;
  word_sel_t word_sel;
  tag_t      tag_rd;            // Stored tag of the selected way
  line_t     line_rd;           // Stored line of the selected way
  line_t     merge_line;
  line_t     wr_line;
  word_t     word_rd;

  //------------------------------
  // Request register and address split
  //------------------------------
  always_ff @(posedge clk) begin
    if (ctrl.req_reg_en) begin
      req_q <= proc_req;
    end
  end

  assign req_tag  = req_q.addr[31 -: tag_bits];
  assign index    = req_q.addr[offset_bits +: index_bits];
  assign word_sel = req_q.addr[offset_bits-1:2];   // Byte bits are ignored
  assign req_type = req_q.req_type;

  //------------------------------
  // Array reads
  //------------------------------
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      match[w] = ctrl.tag_ren && (tag_array[w][index] == req_tag);
    end
  end

  assign tag_rd  = ctrl.tag_ren  ? tag_array[way][index]  : '0;
  assign line_rd = ctrl.data_ren ? data_array[way][index] : '0;
  assign word_rd = line_rd[word_sel*32 +: 32];

  //------------------------------
  // Array writes
  //------------------------------
  // Whole-word store into the current line
  always_comb begin
    merge_line = line_rd;
    merge_line[word_sel*32 +: 32] = req_q.data;
  end

  assign wr_line = ctrl.write_from_refill ? mem_line_q : merge_line;

  always_ff @(posedge clk) begin
    if (ctrl.tag_wen) begin
      tag_array[way][index] <= req_tag;
    end
    if (ctrl.data_wen) begin
      data_array[way][index] <= wr_line;
    end
  end

  //------------------------------
  // Side registers
  //------------------------------
  always_ff @(posedge clk) begin
    if (ctrl.read_reg_en) begin
      read_word_q <= word_rd;
    end
    if (ctrl.evict_addr_reg_en) begin
      evict_addr_q <= {tag_rd, index, {offset_bits{1'b0}}};   // Victim line address
    end
    if (ctrl.mem_resp_reg_en) begin
      mem_line_q <= mem_resp.data;   // Last load is the accepted beat
    end
  end

  //------------------------------
  // Outgoing messages
  //------------------------------
  always_comb begin
    mem_req.req_type = ctrl.mem_req_type;
    if (ctrl.mem_addr_from_evict) begin
      mem_req.addr = evict_addr_q;
    end else begin
      mem_req.addr = {req_tag, index, {offset_bits{1'b0}}};   // Refill line
    end
    mem_req.data = line_rd;          // Victim line during eviction
  end

  always_comb begin
    proc_resp.req_type = req_q.req_type;
    proc_resp.hit      = ctrl.resp_hit;
    proc_resp.data     = (req_q.req_type == req_read) ? read_word_q : '0;
  end

endmodule

/* hw/cache_ctrl.sv */
//------------------------------
// Cache control FSM
// State sequencing and the per-state control table
//------------------------------
`timescale 1ns/100ps

module cache_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  // Processor side handshakes
  input  logic                  proc_req_val,
  output logic                  proc_req_rdy,
  output logic                  proc_resp_val,
  input  logic                  proc_resp_rdy,
  // Memory side handshakes
  output logic                  mem_req_val,
  input  logic                  mem_req_rdy,
  input  logic                  mem_resp_val,
  output logic                  mem_resp_rdy,
  // Status in
  input  cache_pkg::req_type_e  req_type,
  input  logic                  hit,
  input  logic                  victim_dirty,
  // Control out
  output cache_pkg::ctrl_sig_t  ctrl,
  output logic                  set_valid,
  output logic                  set_dirty,
  output logic                  clear_dirty,
  output logic                  lru_update
);
  import cache_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_next;
  logic        hit_q;      // Outcome of the tag check, for the response
  logic [18:0] row;        // Handshakes, datapath controls, metadata strobes

  //------------------------------
  // State register
  //------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= state_idle;
      hit_q   <= 1'b0;
    end else begin
      state_q <= state_next;
      if (state_q == state_tag_check) begin
        hit_q <= hit;
      end
    end
  end

  //------------------------------
  // Next state
  //------------------------------
  always_comb begin
    state_next = state_q;
    case (state_q)
      state_idle:
        if (proc_req_val) state_next = state_tag_check;
      state_tag_check:
        if (hit && req_type == req_read) state_next = state_read_access;
        else if (hit) state_next = state_write_access;
        else if (victim_dirty) state_next = state_evict_prepare;   // Write back first
        else state_next = state_refill_request;
      state_read_access:   state_next = state_resp_wait;
      state_write_access:  state_next = state_resp_wait;
      state_evict_prepare: state_next = state_evict_request;
      state_evict_request:
        if (mem_req_rdy) state_next = state_evict_wait;
      state_evict_wait:
        if (mem_resp_val) state_next = state_refill_request;      // Write acked
      state_refill_request:
        if (mem_req_rdy) state_next = state_refill_wait;
      state_refill_wait:
        if (mem_resp_val) state_next = state_refill_update;
      state_refill_update:
        // Line now present, replay the access as a hit
        if (req_type == req_read) state_next = state_read_access;
        else state_next = state_write_access;
      state_resp_wait:
        if (proc_resp_rdy) state_next = state_idle;
      default: state_next = state_idle;
    endcase
  end

  //------------------------------
  // Control table
  //------------------------------
  // Handshakes:  req_rdy resp_val mem_req_val mem_resp_rdy
  // Datapath:    req_reg mresp_reg tag_ren tag_wen data_ren data_wen
  //              from_refill read_reg evict_reg addr_from_evict mem_type
  // Metadata:    set_valid set_dirty clear_dirty lru_update
  always_comb begin
    case (state_q)
      state_idle:           row = {4'b1000, 11'b1_0_0_0_0_0_0_0_0_0_0, 4'b0000};
      state_tag_check:      row = {4'b0000, 11'b0_0_1_0_0_0_0_0_0_0_0, 4'b0000};
      state_read_access:    row = {4'b0000, 11'b0_0_1_0_1_0_0_1_0_0_0, 4'b0001};
      state_write_access:   row = {4'b0000, 11'b0_0_1_0_1_1_0_0_0_0_0, 4'b0101};
      state_refill_request: row = {4'b0010, 11'b0_0_0_0_0_0_0_0_0_0_0, 4'b0000};
      state_refill_wait:    row = {4'b0001, 11'b0_1_0_0_0_0_0_0_0_0_0, 4'b0000};
      state_refill_update:  row = {4'b0000, 11'b0_0_0_1_0_1_1_0_0_0_0, 4'b1010};
      state_evict_prepare:  row = {4'b0000, 11'b0_0_1_0_0_0_0_0_1_0_0, 4'b0000};
      state_evict_request:  row = {4'b0010, 11'b0_0_0_0_1_0_0_0_0_1_1, 4'b0000};
      state_evict_wait:     row = {4'b0001, 11'b0_0_0_0_0_0_0_0_0_0_0, 4'b0000};
      state_resp_wait:      row = {4'b0100, 11'b0_0_0_0_0_0_0_0_0_0_0, 4'b0000};
      default:              row = '0;
    endcase
  end

  // Unpack the row
  assign {proc_req_rdy, proc_resp_val, mem_req_val, mem_resp_rdy} = row[18:15];
  assign ctrl = ctrl_sig_t'({row[14:4], hit_q});   // resp_hit is the last field
  assign {set_valid, set_dirty, clear_dirty, lru_update} = row[3:0];

endmodule

/* hw/cache_meta.sv */
//------------------------------
// Cache metadata
// Valid, dirty and LRU bits with hit detection and way selection
//------------------------------
`timescale 1ns/100ps

module cache_meta (
  input  logic              clk,
  input  logic              reset,
  input  cache_pkg::index_t index,         // Set of the registered request
  input  logic [1:0]        match,         // Tag compare per way
  input  logic              set_valid,
  input  logic              set_dirty,
  input  logic              clear_dirty,
  input  logic              lru_update,
  output logic              hit,
  output cache_pkg::way_t   way,           // Way used by this access
  output logic              victim_dirty   // Dirty bit of that way
);
  import cache_pkg::*;

  logic [num_sets-1:0][num_ways-1:0] valid_q;
  logic [num_sets-1:0][num_ways-1:0] dirty_q;
  logic [num_sets-1:0]               lru_q;      // Way to replace next

  logic [num_ways-1:0] hit_vec;

  //------------------------------
  // Lookup
  //------------------------------
  assign hit_vec = match & valid_q[index];   // A tag only counts when valid
  assign hit     = |hit_vec;

  // Matching way on a hit, otherwise the LRU victim
  always_comb begin
    if (hit) begin
      way = way_t'(hit_vec[1]);
    end else begin
      way = lru_q[index];
    end
  end

  assign victim_dirty = dirty_q[index][way];

  //------------------------------
  // Update, steered to the selected way
  //------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end else begin
      if (set_valid) begin
        valid_q[index][way] <= 1'b1;   // Only on refill
      end
      if (set_dirty) begin
        dirty_q[index][way] <= 1'b1;
      end else if (clear_dirty) begin
        dirty_q[index][way] <= 1'b0;   // Fresh line matches memory
      end
      if (lru_update) begin
        lru_q[index] <= ~way;          // Other way becomes the victim
      end
    end
  end

endmodule

/* hw/cache_pkg.sv */
//------------------------------
// Cache package
// Geometry, field types, FSM states and the stream messages
//------------------------------

package cache_pkg;

  //------------------------------
  // Geometry
  //------------------------------
  localparam int num_sets       = 8;
  localparam int num_ways       = 2;
  localparam int words_per_line = 4;
  localparam int offset_bits    = 4;   // Byte offset within a 16-byte line
  localparam int index_bits     = 3;
  localparam int tag_bits       = 25;  // 32 - index_bits - offset_bits

  //------------------------------
  // Field types
  //------------------------------
  typedef logic [31:0]                   addr_t;      // Byte address
  typedef logic [31:0]                   word_t;
  typedef logic [words_per_line*32-1:0]  line_t;      // Word 0 in the low bits
  typedef logic [tag_bits-1:0]           tag_t;
  typedef logic [index_bits-1:0]         index_t;
  typedef logic [1:0]                    word_sel_t;  // Word within a line
  typedef logic                          way_t;

  // Transaction type, shared by processor and memory messages
  typedef enum logic {
    req_read  = 1'b0,
    req_write = 1'b1
  } req_type_e;

  // Control FSM states
  typedef enum logic [3:0] {
    state_idle           = 4'd0,
    state_tag_check      = 4'd1,
    state_read_access    = 4'd2,
    state_write_access   = 4'd3,
    state_refill_request = 4'd4,
    state_refill_wait    = 4'd5,
    state_refill_update  = 4'd6,
    state_evict_prepare  = 4'd7,
    state_evict_request  = 4'd8,
    state_evict_wait     = 4'd9,
    state_resp_wait      = 4'd10
  } ctrl_state_e;

  //------------------------------
  // Stream messages
  //------------------------------
  typedef struct packed {
    req_type_e req_type;
    addr_t     addr;
    word_t     data;      // Ignored on reads
  } cache_req_t;          // 65 bits

  typedef struct packed {
    req_type_e req_type;
    logic      hit;
    word_t     data;      // Zero on writes
  } cache_resp_t;         // 34 bits

  typedef struct packed {
    req_type_e req_type;
    addr_t     addr;      // Always line aligned
    line_t     data;
  } mem_req_t;            // 161 bits

  typedef struct packed {
    req_type_e req_type;
    line_t     data;
  } mem_resp_t;           // 129 bits

  // One row of the control table, FSM to datapath
  typedef struct packed {
    logic      req_reg_en;
    logic      mem_resp_reg_en;
    logic      tag_ren;
    logic      tag_wen;
    logic      data_ren;
    logic      data_wen;
    logic      write_from_refill;    // Line source is the refill, not the CPU word
    logic      read_reg_en;
    logic      evict_addr_reg_en;
    logic      mem_addr_from_evict;
    req_type_e mem_req_type;
    logic      resp_hit;
  } ctrl_sig_t;

endpackage
